//--- src/alu_pkg.sv
/* ALU shared types */

package alu_pkg;

    // ------------------------------
    // Datapath width
    // ------------------------------

    // Shift amount width and every bundle below follow from this
    localparam int XLEN = 64;

    // ------------------------------
    // Opcodes
    // ------------------------------

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        SLT  = 4'h2,
        SLTU = 4'h3,
        AND  = 4'h4,
        OR   = 4'h5,
        XOR  = 4'h6,
        SLL  = 4'h7,
        SRL  = 4'h8,
        SRA  = 4'h9
    } alu_op_e;

    // ------------------------------
    // Bundles
    // ------------------------------

    // One operation as presented at the unit's input
    typedef struct packed {
        alu_op_e           op;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
    } alu_in_t;

    // Adder output with the flags needed for compares
    typedef struct packed {
        logic [XLEN-1:0]   sum;
        logic              cout;
        // Signed overflow of a + b or a - b
        logic              ovf;
    } add_res_t;

endpackage

//--- src/cla_adder16.sv
/* Carry-lookahead adder block */

module cla_adder16 #(
    parameter int BLOCK_W = 16
) (
    input  logic [BLOCK_W-1:0] a,
    input  logic [BLOCK_W-1:0] b,
    input  logic               cin,
    output logic [BLOCK_W-1:0] sum,
    output logic               cout,
    output logic               msb_carry
);

    // Per-bit generate and propagate
    logic [BLOCK_W-1:0] g;
    logic [BLOCK_W-1:0] p;

    // span_g[i] / span_p[i] cover bits [i-1:0]
    logic [BLOCK_W:0]   span_g;
    logic [BLOCK_W:0]   span_p;

    logic [BLOCK_W-1:0] carry;
    logic               grp_g;
    logic               grp_p;

    assign g = a & b;
    assign p = a ^ b;

    // ------------------------------
    // Lookahead terms
    // ------------------------------

    // Each span is a flat sum of products, no carry ripple between bits
    always_comb begin
        span_g    = '0;
        span_p    = '0;
        span_p[0] = 1'b1;
        for (int i = 1; i <= BLOCK_W; i++) begin
            span_g[i] = g[i-1];
            span_p[i] = p[i-1];
            for (int j = i - 2; j >= 0; j--) begin
                span_g[i] = span_g[i] | (span_p[i] & g[j]);
                span_p[i] = span_p[i] & p[j];
            end
        end
    end

    // Carry into every bit straight from cin
    always_comb begin
        for (int i = 0; i < BLOCK_W; i++) begin
            carry[i] = span_g[i] | (span_p[i] & cin);
        end
    end

    // Group terms for the block carry-out
    assign grp_g = span_g[BLOCK_W];
    assign grp_p = span_p[BLOCK_W];

    assign sum       = p ^ carry;
    assign cout      = grp_g | (grp_p & cin);
    assign msb_carry = carry[BLOCK_W-1];

endmodule

//--- src/add_sub64.sv
/* 64-bit adder and subtractor */

module add_sub64 #(
    parameter int BLOCK_W = 16
) (
    input  alu_pkg::alu_in_t  op_in,
    output alu_pkg::add_res_t add_res
);

    localparam int NUM_BLK = alu_pkg::XLEN / BLOCK_W;

    logic                      sub;
    logic [alu_pkg::XLEN-1:0]  b_eff;
    logic [alu_pkg::XLEN-1:0]  sum;
    logic [NUM_BLK:0]          blk_carry;
    // Carry into the top bit of each block, only the last one matters
    logic [NUM_BLK-1:0]        blk_msb;

    if (alu_pkg::XLEN % BLOCK_W != 0) begin : g_width_check
        $error("BLOCK_W must divide the datapath width");
    end

    // ------------------------------
    // Operand conditioning
    // ------------------------------

    // Compares are a - b as well
    assign sub = (op_in.op == alu_pkg::SUB) ||
                 (op_in.op == alu_pkg::SLT) ||
                 (op_in.op == alu_pkg::SLTU);

    // Two's complement: ~b plus the carry-in below
    assign b_eff        = sub ? ~op_in.b : op_in.b;
    assign blk_carry[0] = sub;

    // ------------------------------
    // Block chain
    // ------------------------------

    for (genvar i = 0; i < NUM_BLK; i++) begin : g_blk
        cla_adder16 #(
            .BLOCK_W   (BLOCK_W)
        ) u_cla (
            .a         (op_in.a[i*BLOCK_W +: BLOCK_W]),
            .b         (b_eff[i*BLOCK_W +: BLOCK_W]),
            .cin       (blk_carry[i]),
            .sum       (sum[i*BLOCK_W +: BLOCK_W]),
            .cout      (blk_carry[i+1]),
            .msb_carry (blk_msb[i])
        );
    end

    always_comb begin
        add_res.sum  = sum;
        add_res.cout = blk_carry[NUM_BLK];
        // Carry into bit 63 differs from carry out of it
        add_res.ovf  = blk_msb[NUM_BLK-1] ^ blk_carry[NUM_BLK];
    end

    // Mixed-sign add cannot overflow, checks the whole carry chain
    a_add_no_ovf_mixed_sign : assert property (
        @(op_in)
        (op_in.op == alu_pkg::ADD) &&
        (op_in.a[alu_pkg::XLEN-1] != op_in.b[alu_pkg::XLEN-1])
        |-> !add_res.ovf
    ) else $error("overflow on mixed-sign add");

endmodule

//--- src/shift_logic64.sv
/* Shift and logic unit */

module shift_logic64 (
    input  alu_pkg::alu_in_t         op_in,
    output logic [alu_pkg::XLEN-1:0] sl_res
);

    localparam int SHAMT_W = $clog2(alu_pkg::XLEN);

    logic [SHAMT_W-1:0]       shamt;
    logic [alu_pkg::XLEN-1:0] shift_in;
    logic [alu_pkg::XLEN-1:0] shift_out;
    logic [alu_pkg::XLEN:0]   shift_ext;
    logic                     fill;
    logic                     is_left;

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [alu_pkg::XLEN-1:0] bit_rev(
        input logic [alu_pkg::XLEN-1:0] v
    );
        logic [alu_pkg::XLEN-1:0] r;
        for (int i = 0; i < alu_pkg::XLEN; i++) begin
            r[i] = v[alu_pkg::XLEN-1-i];
        end
        return r;
    endfunction

    // ------------------------------
    // Shared right shifter
    // ------------------------------

    assign shamt   = op_in.b[SHAMT_W-1:0];
    assign is_left = (op_in.op == alu_pkg::SLL);

    // Left shift is a right shift of the mirrored operand
    assign shift_in = is_left ? bit_rev(op_in.a) : op_in.a;

    // Sign bit only feeds in for arithmetic shifts
    assign fill = (op_in.op == alu_pkg::SRA) & op_in.a[alu_pkg::XLEN-1];

    // One extra fill bit on top, then arithmetic shift
    assign shift_ext = $unsigned($signed({fill, shift_in}) >>> shamt);
    assign shift_out = is_left ? bit_rev(shift_ext[alu_pkg::XLEN-1:0])
                               : shift_ext[alu_pkg::XLEN-1:0];

    // ------------------------------
    // Result mux
    // ------------------------------

    always_comb begin
        case (op_in.op)
            alu_pkg::AND: begin
                sl_res = op_in.a & op_in.b;
            end
            alu_pkg::OR: begin
                sl_res = op_in.a | op_in.b;
            end
            alu_pkg::XOR: begin
                sl_res = op_in.a ^ op_in.b;
            end
            alu_pkg::SLL,
            alu_pkg::SRL,
            alu_pkg::SRA: begin
                sl_res = shift_out;
            end
            // Adder opcodes belong to add_sub64
            default: begin
                sl_res = '0;
            end
        endcase
    end

endmodule

//--- src/alu_result_sel.sv
/* ALU result stage */

module alu_result_sel (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  alu_pkg::alu_op_e         op,
    input  alu_pkg::add_res_t        add_res,
    input  logic [alu_pkg::XLEN-1:0] sl_res,
    output logic                     out_valid,
    output logic [alu_pkg::XLEN-1:0] result
);

    logic                     lt_signed;
    logic                     lt_unsigned;
    logic [alu_pkg::XLEN-1:0] result_nxt;

    // ------------------------------
    // Compare flags from a - b
    // ------------------------------

    // Sign of the difference, corrected when it overflowed
    assign lt_signed   = add_res.sum[alu_pkg::XLEN-1] ^ add_res.ovf;
    // No carry out means a borrow
    assign lt_unsigned = ~add_res.cout;

    always_comb begin
        case (op)
            alu_pkg::ADD,
            alu_pkg::SUB: begin
                result_nxt = add_res.sum;
            end
            alu_pkg::SLT: begin
                result_nxt = {{(alu_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            alu_pkg::SLTU: begin
                result_nxt = {{(alu_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_nxt = sl_res;
            end
        endcase
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Holds through idle cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (in_valid) begin
            result <= result_nxt;
        end
    end

    a_out_valid_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid)
    ) else $error("out_valid is unknown");

    // Upper encodings 10..15 have no decode
    a_op_legal : assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> op inside {alu_pkg::ADD, alu_pkg::SUB, alu_pkg::SLT,
                                alu_pkg::SLTU, alu_pkg::AND, alu_pkg::OR,
                                alu_pkg::XOR, alu_pkg::SLL, alu_pkg::SRL,
                                alu_pkg::SRA}
    ) else $error("illegal opcode with in_valid high");

endmodule

//--- src/alu64_top.sv
/* 64-bit execute unit */

module alu64_top #(
    parameter int BLOCK_W = 16
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  alu_pkg::alu_in_t         op_in,
    output logic                     out_valid,
    output logic [alu_pkg::XLEN-1:0] result
);

    alu_pkg::add_res_t        add_res;
    logic [alu_pkg::XLEN-1:0] sl_res;

    // ------------------------------
    // Arithmetic half
    // ------------------------------

    add_sub64 #(
        .BLOCK_W (BLOCK_W)
    ) u_add_sub64 (
        .op_in   (op_in),
        .add_res (add_res)
    );

    // ------------------------------
    // Shift and logic half
    // ------------------------------

    shift_logic64 u_shift_logic64 (
        .op_in  (op_in),
        .sl_res (sl_res)
    );

    // ------------------------------
    // Select and register
    // ------------------------------

    alu_result_sel u_alu_result_sel (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op_in.op),
        .add_res   (add_res),
        .sl_res    (sl_res),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- testbench/alu64_checker.sv
/* ALU checker and reference model */

module alu64_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  alu_pkg::alu_in_t         op_in,
    input  logic                     out_valid,
    input  logic [alu_pkg::XLEN-1:0] result,
    input  logic                     phase_done,
    input  int                       phase_num,
    input  logic                     run_done,
    output int                       pass_count,
    output int                       fail_count
);

    // Operation in flight and the result it must produce
    logic                     exp_valid;
    logic [alu_pkg::XLEN-1:0] exp_result;
    alu_pkg::alu_op_e         exp_op;
    int                       phase_pass;
    int                       phase_fail;

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [alu_pkg::XLEN-1:0] model_result(
        input alu_pkg::alu_op_e         op,
        input logic [alu_pkg::XLEN-1:0] a,
        input logic [alu_pkg::XLEN-1:0] b
    );
        logic signed [alu_pkg::XLEN-1:0] sa;
        logic signed [alu_pkg::XLEN-1:0] sb;
        logic [5:0]                      amt;
        sa  = a;
        sb  = b;
        amt = b[5:0];
        case (op)
            alu_pkg::ADD:  return a + b;
            alu_pkg::SUB:  return a - b;
            alu_pkg::SLT:  return (sa < sb) ? 64'd1 : 64'd0;
            alu_pkg::SLTU: return (a < b) ? 64'd1 : 64'd0;
            alu_pkg::AND:  return a & b;
            alu_pkg::OR:   return a | b;
            alu_pkg::XOR:  return a ^ b;
            alu_pkg::SLL:  return a << amt;
            alu_pkg::SRL:  return a >> amt;
            alu_pkg::SRA:  return sa >>> amt;
            default:       return '0;
        endcase
    endfunction

    task automatic compare(
        input string                    name,
        input logic [alu_pkg::XLEN-1:0] expected,
        input logic [alu_pkg::XLEN-1:0] actual
    );
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h (last op %s)",
                     name, expected, actual, exp_op.name());
            fail_count++;
            phase_fail++;
        end else begin
            pass_count++;
            phase_pass++;
        end
    endtask

    // ------------------------------
    // Compare one cycle after accept
    // ------------------------------

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_valid  = 1'b0;
            exp_result = '0;
            exp_op     = alu_pkg::ADD;
            pass_count = 0;
            fail_count = 0;
            phase_pass = 0;
            phase_fail = 0;
        end else begin
            // Idle cycles expect the held result
            compare("out_valid", {63'b0, exp_valid}, {63'b0, out_valid});
            compare("result", exp_result, result);
            if (phase_done) begin
                $display("Phase %0d done: %0d checks passed, %0d failed",
                         phase_num, phase_pass, phase_fail);
                phase_pass = 0;
                phase_fail = 0;
            end
            if (run_done) begin
                $display("All phases: %0d checks passed, %0d failed", pass_count, fail_count);
            end
            if (in_valid) begin
                exp_result = model_result(op_in.op, op_in.a, op_in.b);
                exp_op     = op_in.op;
            end
            exp_valid = in_valid;
        end
    end

endmodule

//--- testbench/tb_alu64.sv
/* ALU testbench */

module tb_alu64;

    localparam int BLOCK_W     = 16;
    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYC     = 4;
    localparam int IDLE_CYC    = 16;
    localparam int PHASE_OPS   = 200;
    localparam int MIX_CYC     = 300;
    // Six phases, each closed by three gap cycles
    localparam int TEST_CYC    = RST_CYC + IDLE_CYC + 4 * PHASE_OPS + MIX_CYC + 6 * 3;
    // Margin for corner operations and the closing report
    localparam int TIMEOUT_CYC = TEST_CYC + 800;

    localparam logic [63:0] ONES    = 64'hffff_ffff_ffff_ffff;
    localparam logic [63:0] MAX_POS = 64'h7fff_ffff_ffff_ffff;
    localparam logic [63:0] MIN_NEG = 64'h8000_0000_0000_0000;

    logic             clk;
    logic             arst_n;
    logic             in_valid;
    alu_pkg::alu_in_t op_in;
    logic             out_valid;
    logic [63:0]      result;
    logic             phase_done;
    int               phase_num;
    logic             run_done;
    int               pass_count;
    int               fail_count;
    integer           seed = 85;
    int               cycle_cnt = 0;

    alu64_top #(
        .BLOCK_W   (BLOCK_W)
    ) u_alu64_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op_in     (op_in),
        .out_valid (out_valid),
        .result    (result)
    );

    alu64_checker u_alu64_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .op_in      (op_in),
        .out_valid  (out_valid),
        .result     (result),
        .phase_done (phase_done),
        .phase_num  (phase_num),
        .run_done   (run_done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic alu_pkg::alu_op_e pick_any_op();
        int unsigned idx;
        idx = $unsigned($random(seed)) % 10;
        return alu_pkg::alu_op_e'(idx[3:0]);
    endfunction

    function automatic alu_pkg::alu_op_e pick_of_two(
        input alu_pkg::alu_op_e x,
        input alu_pkg::alu_op_e y
    );
        return ($random(seed) & 1) ? y : x;
    endfunction

    task automatic issue_op(input alu_pkg::alu_op_e op, input logic [63:0] a,
                            input logic [63:0] b);
        @(posedge clk);
        in_valid <= 1'b1;
        op_in.op <= op;
        op_in.a  <= a;
        op_in.b  <= b;
    endtask

    // Operands keep moving so a held result is really held
    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        op_in.a  <= rand64();
        op_in.b  <= rand64();
    endtask

    task automatic issue_compare_pair(input logic [63:0] a, input logic [63:0] b);
        issue_op(alu_pkg::SLT, a, b);
        issue_op(alu_pkg::SLTU, a, b);
    endtask

    task automatic end_phase(input int num);
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        phase_done <= 1'b1;
        phase_num  <= num;
        @(posedge clk);
        phase_done <= 1'b0;
    endtask

    // ------------------------------
    // Test phases
    // ------------------------------

    initial begin
        logic [63:0] a;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        op_in      = '0;
        phase_done = 1'b0;
        phase_num  = 0;
        run_done   = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        arst_n <= 1'b1;

        repeat (IDLE_CYC) idle_cycle();
        end_phase(1);

        issue_op(alu_pkg::ADD, ONES, 64'd1);
        issue_op(alu_pkg::SUB, 64'd0, 64'd1);
        issue_op(alu_pkg::SUB, MIN_NEG, 64'd1);
        issue_op(alu_pkg::ADD, MAX_POS, 64'd1);
        for (int i = 0; i < PHASE_OPS; i++) begin
            issue_op(pick_of_two(alu_pkg::ADD, alu_pkg::SUB), rand64(), rand64());
        end
        end_phase(2);

        a = rand64();
        issue_compare_pair(a, a);
        issue_compare_pair(ONES, 64'd1);
        issue_compare_pair(64'd1, ONES);
        issue_compare_pair(MIN_NEG, MAX_POS);
        issue_compare_pair(MAX_POS, MIN_NEG);
        for (int i = 0; i < PHASE_OPS; i++) begin
            issue_op(pick_of_two(alu_pkg::SLT, alu_pkg::SLTU), rand64(), rand64());
        end
        end_phase(3);

        for (int i = 0; i < PHASE_OPS; i++) begin
            issue_op(alu_pkg::alu_op_e'(4 + $unsigned($random(seed)) % 3), rand64(), rand64());
        end
        end_phase(4);

        issue_op(alu_pkg::SLL, rand64(), 64'd0);
        issue_op(alu_pkg::SLL, ONES, 64'd63);
        issue_op(alu_pkg::SRL, ONES, 64'd63);
        issue_op(alu_pkg::SRA, MIN_NEG, 64'd63);
        issue_op(alu_pkg::SRA, rand64() | MIN_NEG, 64'd0);
        issue_op(alu_pkg::SRA, ONES - 64'd255, 64'd68);
        for (int i = 0; i < PHASE_OPS; i++) begin
            issue_op(alu_pkg::alu_op_e'(7 + $unsigned($random(seed)) % 3), rand64(), rand64());
        end
        end_phase(5);

        for (int i = 0; i < MIX_CYC; i++) begin
            if ($unsigned($random(seed)) % 10 < 3) begin
                idle_cycle();
            end else begin
                issue_op(pick_any_op(), rand64(), rand64());
            end
        end
        end_phase(6);

        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        @(negedge clk);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
src/alu_pkg.sv
src/cla_adder16.sv
src/add_sub64.sv
src/shift_logic64.sv
src/alu_result_sel.sv
src/alu64_top.sv
testbench/alu64_checker.sv
testbench/tb_alu64.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_alu64
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
